/* Bender.yml */
package:
  name: lsu_datapath

sources:
  - lsu_pkg.sv
  - lsu_addr_gen.sv
  - lsu_store_align.sv
  - lsu_load_align.sv
  - lsu_datapath.sv
  - target: test
    files:
      - tb_lsu_datapath.sv

/* lsu_addr_gen.sv */
/*
 * lsu address generation.
 * adds base and offset, decodes the access size, checks alignment
 * and raises the bus request.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen (
  input  logic                     req_vld,
  input  logic                     req_store,
  input  logic                     req_byte,
  input  logic                     req_half,
  input  logic                     req_uns,
  input  logic [lsu_pkg::xlen-1:0] req_base,
  input  logic [lsu_pkg::xlen-1:0] req_offset,
  input  logic                     bus_grnt,
  output logic [lsu_pkg::xlen-1:0] bus_addr,
  output logic [1:0]               bus_size,
  output logic                     bus_write,
  output logic                     bus_req,
  output logic                     misalign,
  output logic                     accepted,
  output logic                     ld_sign,
  output logic [1:0]               acc_addr_lo
);
  import lsu_pkg::*;

  logic [xlen-1:0] addr_sum;
  logic [1:0]      size_dec;
  logic [1:0]      addr_mask;

  assign addr_sum = req_base + req_offset;

  // byte wins over half, anything else is a word.
  assign size_dec = req_byte ? size_byte :
                    req_half ? size_half : size_word;

  always_comb
  begin
    case (size_dec)
      size_word:
      begin
        addr_mask = 2'b00;
        misalign  = |addr_sum[1:0];
      end
      size_half:
      begin
        addr_mask = 2'b10;
        misalign  = addr_sum[0];
      end
      default:
      begin
        addr_mask = 2'b11;
        misalign  = 1'b0;
      end
    endcase
  end

  assign bus_addr    = {addr_sum[xlen-1:2], addr_sum[1:0] & addr_mask};
  assign bus_size    = size_dec;
  assign bus_write   = req_store;

  // a misaligned access never reaches the bus.
  assign bus_req     = req_vld && !misalign;
  assign accepted    = bus_req && bus_grnt;

  assign ld_sign     = !req_uns;
  assign acc_addr_lo = bus_addr[1:0];

endmodule

`default_nettype wire

/* lsu_datapath.sv */
/*
 * lsu data path top level.
 * joins address generation, store and load alignment between the
 * core and the request/grant bus.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_datapath (
  input  logic                     size_buf_clk,
  input  logic                     cpurst_b,
  input  logic [1:0]               endian_mode,
  input  logic                     req_vld,
  input  logic                     req_store,
  input  logic                     req_byte,
  input  logic                     req_half,
  input  logic                     req_uns,
  input  logic [lsu_pkg::xlen-1:0] req_base,
  input  logic [lsu_pkg::xlen-1:0] req_offset,
  input  logic [lsu_pkg::xlen-1:0] req_wdata,
  output logic [lsu_pkg::xlen-1:0] bus_addr,
  output logic [1:0]               bus_size,
  output logic                     bus_write,
  output logic                     bus_req,
  input  logic                     bus_grnt,
  output logic [lsu_pkg::xlen-1:0] bus_wdata,
  input  logic [lsu_pkg::xlen-1:0] bus_rdata,
  input  logic                     bus_rdata_vld,
  output logic                     misalign,
  output logic [lsu_pkg::xlen-1:0] load_data,
  output logic                     load_data_vld
);

  logic       accepted;
  logic       ld_sign;
  logic [1:0] acc_addr_lo;

  lsu_addr_gen u_addr_gen (
    .req_vld     (req_vld),
    .req_store   (req_store),
    .req_byte    (req_byte),
    .req_half    (req_half),
    .req_uns     (req_uns),
    .req_base    (req_base),
    .req_offset  (req_offset),
    .bus_grnt    (bus_grnt),
    .bus_addr    (bus_addr),
    .bus_size    (bus_size),
    .bus_write   (bus_write),
    .bus_req     (bus_req),
    .misalign    (misalign),
    .accepted    (accepted),
    .ld_sign     (ld_sign),
    .acc_addr_lo (acc_addr_lo)
  );

  lsu_store_align u_store_align (
    .size_buf_clk (size_buf_clk),
    .cpurst_b     (cpurst_b),
    .endian_mode  (endian_mode),
    .req_store    (req_store),
    .accepted     (accepted),
    .bus_size     (bus_size),
    .acc_addr_lo  (acc_addr_lo),
    .req_wdata    (req_wdata),
    .bus_wdata    (bus_wdata)
  );

  lsu_load_align u_load_align (
    .size_buf_clk  (size_buf_clk),
    .cpurst_b      (cpurst_b),
    .endian_mode   (endian_mode),
    .req_store     (req_store),
    .accepted      (accepted),
    .ld_sign       (ld_sign),
    .bus_size      (bus_size),
    .acc_addr_lo   (acc_addr_lo),
    .bus_rdata     (bus_rdata),
    .bus_rdata_vld (bus_rdata_vld),
    .load_data     (load_data),
    .load_data_vld (load_data_vld)
  );

endmodule

`default_nettype wire

/* lsu_load_align.sv */
/*
 * lsu load aligner.
 * keeps the load info captured at grant and uses it to steer and
 * extend the returned read data.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                     size_buf_clk,
  input  logic                     cpurst_b,
  input  logic [1:0]               endian_mode,
  input  logic                     req_store,
  input  logic                     accepted,
  input  logic                     ld_sign,
  input  logic [1:0]               bus_size,
  input  logic [1:0]               acc_addr_lo,
  input  logic [lsu_pkg::xlen-1:0] bus_rdata,
  input  logic                     bus_rdata_vld,
  output logic [lsu_pkg::xlen-1:0] load_data,
  output logic                     load_data_vld
);
  import lsu_pkg::*;

  logic       info_sign;
  logic [1:0] info_size;
  logic [1:0] info_addr_lo;
  logic [1:0] elem_mask;
  logic [2:0] elem_bytes;
  logic [1:0] elem_base;
  bus_word_u  rd_word;
  bus_word_u  sized;

  // load info buffer, only a granted load may overwrite it.
  always_ff @(posedge size_buf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      info_sign    <= 1'b0;
      info_size    <= '0;
      info_addr_lo <= '0;
    end
    else if (accepted && !req_store)
    begin
      info_sign    <= ld_sign;
      info_size    <= bus_size;
      info_addr_lo <= acc_addr_lo;
    end
  end

  always_comb
  begin
    case (info_size)
      size_byte:
      begin
        elem_mask  = 2'b11;
        elem_bytes = 3'd1;
      end
      size_half:
      begin
        elem_mask  = 2'b10;
        elem_bytes = 3'd2;
      end
      default:
      begin
        elem_mask  = 2'b00;
        elem_bytes = 3'd4;
      end
    endcase
  end

  assign elem_base = (endian_mode == endian_be_v1) ? (~info_addr_lo & elem_mask) :
                                                     (info_addr_lo & elem_mask);

  // inverse of the store steering, element bytes land in the low lanes.
  always_comb
  begin
    logic [2:0] offs;
    logic [1:0] src_lane;
    offs         = '0;
    src_lane     = '0;
    rd_word.word = bus_rdata;
    sized.word   = '0;
    for (int j = 0; j < lane_num; j++)
    begin
      if (3'(j) < elem_bytes)
      begin
        if (endian_mode == endian_be_v2)
          offs = elem_bytes - 3'd1 - 3'(j);
        else
          offs = 3'(j);
        src_lane       = elem_base + offs[1:0];
        sized.lanes[j] = rd_word.lanes[src_lane];
      end
    end
  end

  // upper lanes are already zero, so only the signed case fills them.
  always_comb
  begin
    case (info_size)
      size_byte:
        load_data = {{(xlen-8){info_sign & sized.lanes[0][7]}}, sized.lanes[0]};
      size_half:
        load_data = {{(xlen-16){info_sign & sized.lanes[1][7]}}, sized.word[15:0]};
      default:
        load_data = sized.word;
    endcase
  end

  assign load_data_vld = bus_rdata_vld;

endmodule

`default_nettype wire

/* lsu_pkg.sv */
/*
 * lsu data path shared definitions.
 * access-size and endian-mode codes, data width and the bus word view.
 */
`default_nettype none

package lsu_pkg;

  // data and address width of the core.
  localparam int xlen     = 32;
  localparam int lane_num = xlen / 8;

  // access size as carried on bus_size.
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  // endian mode, encoded as {be_v1, be_v2}.
  localparam logic [1:0] endian_le    = 2'd0;
  localparam logic [1:0] endian_be_v1 = 2'd2;
  localparam logic [1:0] endian_be_v2 = 2'd1;

  // one bus word, seen whole or as byte lanes with lane 0 at the lsb.
  typedef union packed {
    logic [xlen-1:0]         word;
    logic [lane_num-1:0][7:0] lanes;
  } bus_word_u;

endpackage

`default_nettype wire

/* lsu_store_align.sv */
/*
 * lsu store aligner.
 * steers store data into bus byte lanes and holds it in the
 * store data buffer that drives the bus after the grant.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  logic                     size_buf_clk,
  input  logic                     cpurst_b,
  input  logic [1:0]               endian_mode,
  input  logic                     req_store,
  input  logic                     accepted,
  input  logic [1:0]               bus_size,
  input  logic [1:0]               acc_addr_lo,
  input  logic [lsu_pkg::xlen-1:0] req_wdata,
  output logic [lsu_pkg::xlen-1:0] bus_wdata
);
  import lsu_pkg::*;

  bus_word_u       src_word;
  bus_word_u       steered;
  logic [1:0]      elem_mask;
  logic [2:0]      elem_bytes;
  logic [1:0]      elem_base;
  logic [xlen-1:0] store_data_buf;

  always_comb
  begin
    case (bus_size)
      size_byte:
      begin
        elem_mask  = 2'b11;
        elem_bytes = 3'd1;
      end
      size_half:
      begin
        elem_mask  = 2'b10;
        elem_bytes = 3'd2;
      end
      default:
      begin
        elem_mask  = 2'b00;
        elem_bytes = 3'd4;
      end
    endcase
  end

  // word-invariant big endian mirrors the element position in the word.
  assign elem_base = (endian_mode == endian_be_v1) ? (~acc_addr_lo & elem_mask) :
                                                     (acc_addr_lo & elem_mask);

  always_comb
  begin
    logic [2:0] offs;
    logic [2:0] byte_idx;
    offs         = '0;
    byte_idx     = '0;
    src_word.word = req_wdata;
    steered.word  = '0;
    for (int l = 0; l < lane_num; l++)
    begin
      offs = 3'(l) - {1'b0, elem_base};
      // lanes below the element wrap to a large offset and stay zero.
      if (offs < elem_bytes)
      begin
        if (endian_mode == endian_be_v2)
          byte_idx = elem_bytes - 3'd1 - offs;
        else
          byte_idx = offs;
        steered.lanes[l] = src_word.lanes[byte_idx[1:0]];
      end
    end
  end

  // updated on a granted store, held until the next one.
  always_ff @(posedge size_buf_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      store_data_buf <= '0;
    else if (accepted && req_store)
      store_data_buf <= steered.word;
  end

  assign bus_wdata = store_data_buf;

endmodule

`default_nettype wire

/* src.f */
lsu_pkg.sv
lsu_addr_gen.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_datapath.sv
tb_lsu_datapath.sv

/* tb_lsu_datapath.sv */
/*
 * testbench for the lsu data path.
 * drives random loads and stores, answers as the bus and checks
 * the results against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_datapath;
  import lsu_pkg::*;

  localparam int per_test    = 40;
  localparam int n_misalign  = 8;
  localparam int n_transfers = 3 * per_test + n_misalign;
  localparam int cycle_limit = n_transfers * 8 + 50;

  logic        size_buf_clk;
  logic        cpurst_b;
  logic [1:0]  endian_mode;
  logic        req_vld;
  logic        req_store;
  logic        req_byte;
  logic        req_half;
  logic        req_uns;
  logic [31:0] req_base;
  logic [31:0] req_offset;
  logic [31:0] req_wdata;
  logic [31:0] bus_addr;
  logic [1:0]  bus_size;
  logic        bus_write;
  logic        bus_req;
  logic        bus_grnt;
  logic [31:0] bus_wdata;
  logic [31:0] bus_rdata;
  logic        bus_rdata_vld;
  logic        misalign;
  logic [31:0] load_data;
  logic        load_data_vld;

  logic [31:0] lfsr;
  logic [31:0] mem [4];
  logic [31:0] last_wdata;
  string       cur_test;
  int          test_checks;
  int          test_errs;
  int          total_checks = 0;
  int          total_errs = 0;
  int          n_tests = 0;
  int          cycles = 0;

  lsu_datapath dut (
    .size_buf_clk  (size_buf_clk),
    .cpurst_b      (cpurst_b),
    .endian_mode   (endian_mode),
    .req_vld       (req_vld),
    .req_store     (req_store),
    .req_byte      (req_byte),
    .req_half      (req_half),
    .req_uns       (req_uns),
    .req_base      (req_base),
    .req_offset    (req_offset),
    .req_wdata     (req_wdata),
    .bus_addr      (bus_addr),
    .bus_size      (bus_size),
    .bus_write     (bus_write),
    .bus_req       (bus_req),
    .bus_grnt      (bus_grnt),
    .bus_wdata     (bus_wdata),
    .bus_rdata     (bus_rdata),
    .bus_rdata_vld (bus_rdata_vld),
    .misalign      (misalign),
    .load_data     (load_data),
    .load_data_vld (load_data_vld)
  );

  initial
  begin
    size_buf_clk = 1'b0;
    forever
      #10 size_buf_clk = ~size_buf_clk;
  end

  always @(posedge size_buf_clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // galois lfsr, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hb4bc_d35c) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // flag selector 3 sets both byte and half, byte wins.
  function automatic logic [1:0] size_of(input logic [1:0] szsel);
    if (szsel == 2'd2)
      return size_word;
    if (szsel == 2'd1)
      return size_half;
    return size_byte;
  endfunction

  function automatic int elem_len(input logic [1:0] sz);
    if (sz == size_byte)
      return 1;
    if (sz == size_half)
      return 2;
    return 4;
  endfunction

  // bus lane that carries byte k of an n-byte element.
  function automatic int lane_of(input logic [1:0] mode, input int a_lo, input int n,
                                 input int k);
    if (mode == endian_be_v1)
      return 4 - n - a_lo + k;
    if (mode == endian_be_v2)
      return a_lo + n - 1 - k;
    return a_lo + k;
  endfunction

  function automatic logic [31:0] store_model(input logic [1:0] mode, input int a_lo,
                                              input int n, input logic [31:0] data);
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < n; k++)
      w[8*lane_of(mode, a_lo, n, k) +: 8] = data[8*k +: 8];
    return w;
  endfunction

  function automatic logic [31:0] load_model(input logic [1:0] mode, input int a_lo,
                                             input int n, input logic sgn,
                                             input logic [31:0] rdata);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = rdata[8*lane_of(mode, a_lo, n, k) +: 8];
    if (sgn && n < 4 && v[8*n-1])
      v = v | (32'hffff_ffff << (8 * n));
    return v;
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    if (act !== exp)
    begin
      $display("Fail %s (%s): expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errs);
    n_tests++;
    total_checks += test_checks;
    total_errs   += test_errs;
  endtask

  // the address low bits are forced to lo.
  task automatic drive_request(input logic store, input logic [1:0] szsel,
                               input logic [1:0] lo);
    logic [31:0] sum;
    req_vld    = 1'b1;
    req_store  = store;
    req_byte   = (szsel == 2'd0) || (szsel == 2'd3);
    req_half   = (szsel == 2'd1) || (szsel == 2'd3);
    req_uns    = 1'(rand_bits(1));
    req_base   = rand_bits(32);
    req_offset = rand_bits(32);
    req_wdata  = rand_bits(32);
    sum        = req_base + req_offset;
    req_offset = req_offset - {30'd0, sum[1:0]} + {30'd0, lo};
  endtask

  // the core is free to change its request inputs after the grant.
  task automatic release_request();
    req_vld    = 1'b0;
    req_store  = 1'(rand_bits(1));
    req_byte   = 1'(rand_bits(1));
    req_half   = 1'(rand_bits(1));
    req_uns    = 1'(rand_bits(1));
    req_base   = rand_bits(32);
    req_offset = rand_bits(32);
    req_wdata  = rand_bits(32);
  endtask

  task automatic check_request(input logic [1:0] sz, input logic [31:0] addr,
                               input logic ok);
    compare("bus_addr", addr, bus_addr);
    compare("bus_size", {30'd0, sz}, {30'd0, bus_size});
    compare("bus_write", {31'd0, req_store}, {31'd0, bus_write});
    compare("bus_req", {31'd0, ok}, {31'd0, bus_req});
    compare("misalign", {31'd0, !ok}, {31'd0, misalign});
  endtask

  task automatic run_transfer();
    logic        store;
    logic [1:0]  szsel;
    logic [1:0]  sz;
    logic [1:0]  lo;
    logic [31:0] addr;
    logic [31:0] exp;
    logic [31:0] mask;
    logic [31:0] wdata;
    logic        sgn;
    int          n;
    int          gdly;
    int          lat;
    int          idx;
    store = 1'(rand_bits(1));
    szsel = 2'(rand_bits(2));
    sz    = size_of(szsel);
    n     = elem_len(sz);
    lo    = 2'(rand_bits(2)) & 2'(4 - n);
    gdly  = rand_bits(2);
    lat   = 1 + rand_bits(2) % 3;
    @(posedge size_buf_clk);
    #1;
    drive_request(store, szsel, lo);
    addr  = req_base + req_offset;
    idx   = addr[3:2];
    wdata = req_wdata;
    sgn   = !req_uns;
    // request must stay stable while the grant is held off.
    for (int i = 0; i <= gdly; i++)
    begin
      bus_grnt = (i == gdly);
      @(negedge size_buf_clk);
      check_request(sz, addr, 1'b1);
      @(posedge size_buf_clk);
      #1;
    end
    bus_grnt = 1'b0;
    release_request();
    if (store)
    begin
      exp  = store_model(endian_mode, lo, n, wdata);
      mask = store_model(endian_mode, lo, n, 32'hffff_ffff);
      @(negedge size_buf_clk);
      compare("store lanes", exp, bus_wdata);
      mem[idx]   = (mem[idx] & ~mask) | exp;
      last_wdata = exp;
    end
    else
    begin
      for (int j = 1; j < lat; j++)
      begin
        @(negedge size_buf_clk);
        compare("store data hold", last_wdata, bus_wdata);
        @(posedge size_buf_clk);
        #1;
      end
      bus_rdata     = mem[idx];
      bus_rdata_vld = 1'b1;
      exp           = load_model(endian_mode, lo, n, sgn, mem[idx]);
      @(negedge size_buf_clk);
      compare("load valid", 32'd1, {31'd0, load_data_vld});
      compare("load data", exp, load_data);
      @(posedge size_buf_clk);
      #1;
      bus_rdata_vld = 1'b0;
    end
  endtask

  // the bus grants all along, a blocked request must still stay off.
  task automatic run_misaligned();
    logic        store;
    logic [1:0]  szsel;
    logic [1:0]  lo;
    logic [31:0] addr;
    logic [31:0] exp_addr;
    store = 1'(rand_bits(1));
    szsel = rand_bits(1) ? 2'd2 : 2'd1;
    if (szsel == 2'd1)
      lo = 2'(rand_bits(1) * 2 + 1);
    else
      lo = 2'(1 + rand_bits(2) % 3);
    @(posedge size_buf_clk);
    #1;
    drive_request(store, szsel, lo);
    addr     = req_base + req_offset;
    exp_addr = addr & ~(32'(elem_len(size_of(szsel))) - 32'd1);
    bus_grnt = 1'b1;
    repeat (3)
    begin
      @(negedge size_buf_clk);
      check_request(size_of(szsel), exp_addr, 1'b0);
      compare("store data hold", last_wdata, bus_wdata);
      @(posedge size_buf_clk);
      #1;
    end
    bus_grnt = 1'b0;
    req_vld  = 1'b0;
  endtask

  task automatic run_traffic(input string name, input logic [1:0] mode);
    start_test(name);
    @(posedge size_buf_clk);
    #1;
    endian_mode = mode;
    repeat (per_test)
      run_transfer();
    end_test();
  endtask

  initial
  begin
    cpurst_b      = 1'b0;
    endian_mode   = endian_le;
    req_vld       = 1'b0;
    req_store     = 1'b0;
    req_byte      = 1'b0;
    req_half      = 1'b0;
    req_uns       = 1'b0;
    req_base      = '0;
    req_offset    = '0;
    req_wdata     = '0;
    bus_grnt      = 1'b0;
    bus_rdata     = '0;
    bus_rdata_vld = 1'b0;
    last_wdata    = '0;
    lfsr          = 32'd7;
    for (int i = 0; i < 4; i++)
      mem[i] = rand_bits(32);
    repeat (4) @(posedge size_buf_clk);
    #1;
    cpurst_b = 1'b1;

    start_test("reset_state");
    repeat (2)
    begin
      @(negedge size_buf_clk);
      compare("bus_wdata after reset", 32'd0, bus_wdata);
      compare("load_data_vld after reset", 32'd0, {31'd0, load_data_vld});
      compare("bus_req idle", 32'd0, {31'd0, bus_req});
    end
    end_test();

    run_traffic("traffic_le", endian_le);
    run_traffic("traffic_be_v1", endian_be_v1);
    run_traffic("traffic_be_v2", endian_be_v2);

    start_test("misalign");
    repeat (n_misalign)
      run_misaligned();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, total_checks, total_errs);
    if (total_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
